// ==== verilog/isa_pkg.sv ====
package isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and basic types
  ////////////////////////////////////////////////////////////////////////////

  localparam int xlen = 32;

  typedef logic [4:0]      reg_idx_t;
  typedef logic [xlen-1:0] data_t;

  // Major opcodes, bits 6:0 of the word.
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_fence  = 7'b0001111,
    opc_op_imm = 7'b0010011,
    opc_auipc  = 7'b0010111,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jalr   = 7'b1100111,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_t;

  // ALU function codes carried in funct3.
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction formats
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_t    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_idx_t    rd;
    opcode_t     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    opcode_t    opcode;
  } j_fmt_t;

  // One word, six views.
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_t;

endpackage

// ==== verilog/ctrl_pkg.sv ====
package ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Control field encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,
    alu_sltu   = 4'd4,
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    alu_pass_b = 4'd10
  } alu_op_t;

  typedef enum logic [1:0] {
    src_a_rs1  = 2'd0,
    src_a_pc   = 2'd1,
    src_a_zero = 2'd2
  } alu_src_a_t;

  typedef enum logic {
    src_b_rs2 = 1'b0,
    src_b_imm = 1'b1
  } alu_src_b_t;

  typedef enum logic [1:0] {
    res_alu      = 2'd0,
    res_mem      = 2'd1,
    res_pc_plus4 = 2'd2
  } result_src_t;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic             en;
    isa_pkg::reg_idx_t rd;
    isa_pkg::data_t    data;
  } wb_t;

  typedef struct packed {
    logic              valid;
    logic              reg_write;
    logic              mem_write;
    logic              mem_read;
    logic              branch;
    logic              jump;
    alu_op_t           alu_op;
    alu_src_a_t        alu_src_a;
    alu_src_b_t        alu_src_b;
    result_src_t       result_src;
    logic [2:0]        funct3;
    isa_pkg::reg_idx_t rd;
    isa_pkg::reg_idx_t rs1;
    isa_pkg::reg_idx_t rs2;
    isa_pkg::data_t    rd1;
    isa_pkg::data_t    rd2;
    isa_pkg::data_t    imm;
  } id_ex_t;

endpackage

// ==== verilog/instr_decoder.sv ====
module instr_decoder
  ( input  isa_pkg::instr_t   instr
  , output ctrl_pkg::id_ex_t  dec
  , output isa_pkg::reg_idx_t rs1
  , output isa_pkg::reg_idx_t rs2
  );

  isa_pkg::data_t imm_i;
  isa_pkg::data_t imm_s;
  isa_pkg::data_t imm_b;
  isa_pkg::data_t imm_u;
  isa_pkg::data_t imm_j;
  logic           bit30;

  // ALU function from funct3; alt is the effective bit 30.
  function automatic ctrl_pkg::alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt);
    ctrl_pkg::alu_op_t op;
    case (f3)
      isa_pkg::f3_add_sub: op = alt ? ctrl_pkg::alu_sub : ctrl_pkg::alu_add;
      isa_pkg::f3_sll:     op = ctrl_pkg::alu_sll;
      isa_pkg::f3_slt:     op = ctrl_pkg::alu_slt;
      isa_pkg::f3_sltu:    op = ctrl_pkg::alu_sltu;
      isa_pkg::f3_xor:     op = ctrl_pkg::alu_xor;
      isa_pkg::f3_srl_sra: op = alt ? ctrl_pkg::alu_sra : ctrl_pkg::alu_srl;
      isa_pkg::f3_or:      op = ctrl_pkg::alu_or;
      default:             op = ctrl_pkg::alu_and;
    endcase
    return op;
  endfunction

  assign bit30 = instr.r_fmt.funct7[5];

  // Sign-extended immediates, one per format.
  assign imm_i = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
  assign imm_s = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5, instr.s_fmt.imm_4_0};
  assign imm_b = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                  instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {instr.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                  instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};

  assign rs1 = instr.r_fmt.rs1;
  assign rs2 = instr.r_fmt.rs2;

  always_comb begin
    dec        = '0;
    dec.funct3 = instr.r_fmt.funct3;
    dec.rd     = instr.r_fmt.rd;
    dec.rs1    = instr.r_fmt.rs1;
    dec.rs2    = instr.r_fmt.rs2;
    dec.imm    = imm_i;

    case (instr.r_fmt.opcode)
      isa_pkg::opc_op: begin
        dec.reg_write = 1'b1;
        dec.alu_op    = alu_from_funct3(instr.r_fmt.funct3, bit30);
      end
      isa_pkg::opc_op_imm: begin
        // Bit 30 is part of the immediate except for the right shifts.
        dec.reg_write = 1'b1;
        dec.alu_src_b = ctrl_pkg::src_b_imm;
        dec.alu_op    = alu_from_funct3(instr.r_fmt.funct3,
                          bit30 && (instr.r_fmt.funct3 == isa_pkg::f3_srl_sra));
      end
      isa_pkg::opc_load: begin
        dec.reg_write  = 1'b1;
        dec.mem_read   = 1'b1;
        dec.alu_src_b  = ctrl_pkg::src_b_imm;
        dec.result_src = ctrl_pkg::res_mem;
      end
      isa_pkg::opc_store: begin
        dec.mem_write = 1'b1;
        dec.alu_src_b = ctrl_pkg::src_b_imm;
        dec.imm       = imm_s;
      end
      isa_pkg::opc_branch: begin
        dec.branch = 1'b1;
        dec.alu_op = ctrl_pkg::alu_sub;
        dec.imm    = imm_b;
      end
      isa_pkg::opc_lui: begin
        dec.reg_write = 1'b1;
        dec.alu_op    = ctrl_pkg::alu_pass_b;
        dec.alu_src_a = ctrl_pkg::src_a_zero;
        dec.alu_src_b = ctrl_pkg::src_b_imm;
        dec.imm       = imm_u;
      end
      isa_pkg::opc_auipc: begin
        dec.reg_write = 1'b1;
        dec.alu_src_a = ctrl_pkg::src_a_pc;
        dec.alu_src_b = ctrl_pkg::src_b_imm;
        dec.imm       = imm_u;
      end
      isa_pkg::opc_jal: begin
        dec.reg_write  = 1'b1;
        dec.jump       = 1'b1;
        dec.alu_src_a  = ctrl_pkg::src_a_pc;
        dec.alu_src_b  = ctrl_pkg::src_b_imm;
        dec.result_src = ctrl_pkg::res_pc_plus4;
        dec.imm        = imm_j;
      end
      isa_pkg::opc_jalr: begin
        dec.reg_write  = 1'b1;
        dec.jump       = 1'b1;
        dec.alu_src_b  = ctrl_pkg::src_b_imm;
        dec.result_src = ctrl_pkg::res_pc_plus4;
      end
      // FENCE, SYSTEM and unknown opcodes leave every control field at zero.
      default: ;
    endcase
  end

endmodule

// ==== verilog/reg_file.sv ====
module reg_file
  ( input  logic              clk
  , input  logic              reset
  , input  isa_pkg::reg_idx_t rs1
  , input  isa_pkg::reg_idx_t rs2
  , input  ctrl_pkg::wb_t     wb
  , output isa_pkg::data_t    rd1
  , output isa_pkg::data_t    rd2
  );

  // x0 has no storage.
  isa_pkg::data_t regs [1:31];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // No write-to-read bypass.
  assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== verilog/decode_stage.sv ====
module decode_stage
  ( input  logic             clk
  , input  logic             reset
  , input  isa_pkg::instr_t  instr
  , input  logic             instr_valid
  , input  ctrl_pkg::wb_t    wb
  , output ctrl_pkg::id_ex_t id_ex
  );

  ctrl_pkg::id_ex_t  dec;
  ctrl_pkg::id_ex_t  stage_d;
  isa_pkg::reg_idx_t rs1;
  isa_pkg::reg_idx_t rs2;
  isa_pkg::data_t    rd1;
  isa_pkg::data_t    rd2;

  instr_decoder u_decoder
    ( .instr ( instr )
    , .dec   ( dec   )
    , .rs1   ( rs1   )
    , .rs2   ( rs2   )
    );

  reg_file u_reg_file
    ( .clk   ( clk   )
    , .reset ( reset )
    , .rs1   ( rs1   )
    , .rs2   ( rs2   )
    , .wb    ( wb    )
    , .rd1   ( rd1   )
    , .rd2   ( rd2   )
    );

  ////////////////////////////////////////////////////////////////////////////
  // Decode-to-execute register
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    stage_d     = dec;
    stage_d.rd1 = rd1;
    stage_d.rd2 = rd2;
    // Every decoded opcode has a side effect; bubbles have none.
    stage_d.valid = instr_valid &
                    (dec.reg_write | dec.mem_write | dec.branch | dec.jump);
    if (!stage_d.valid) begin
      stage_d.reg_write  = 1'b0;
      stage_d.mem_write  = 1'b0;
      stage_d.mem_read   = 1'b0;
      stage_d.branch     = 1'b0;
      stage_d.jump       = 1'b0;
      stage_d.alu_op     = ctrl_pkg::alu_add;
      stage_d.alu_src_a  = ctrl_pkg::src_a_rs1;
      stage_d.alu_src_b  = ctrl_pkg::src_b_rs2;
      stage_d.result_src = ctrl_pkg::res_alu;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex <= '0;
    end else begin
      id_ex <= stage_d;
    end
  end

endmodule

// ==== sim/clk_gen.sv ====
module clk_gen
  ( output logic clk
  , output logic reset
  );

  localparam int half_period = 10;

  initial begin
    clk = 1'b0;
    forever begin
      #half_period clk = ~clk;
    end
  end

  // Held over the first two rising edges, dropped on a falling edge.
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

// ==== sim/tb_decode_stage.sv ====
module tb_decode_stage;

  localparam int max_vectors   = 1000;
  localparam int reset_timeout = 20;

  logic             clk;
  logic             reset;
  isa_pkg::instr_t  instr;
  logic             instr_valid;
  ctrl_pkg::wb_t    wb;
  ctrl_pkg::id_ex_t id_ex;

  clk_gen u_clk_gen
    ( .clk   ( clk   )
    , .reset ( reset )
    );

  decode_stage dut0
    ( .clk         ( clk         )
    , .reset       ( reset       )
    , .instr       ( instr       )
    , .instr_valid ( instr_valid )
    , .wb          ( wb          )
    , .id_ex       ( id_ex       )
    );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED at time %0t: %s expected %h, got %h", $time, name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  // Field by field compare of the registered bundle.
  task automatic compare_bundle(input ctrl_pkg::id_ex_t exp);
    check_value("valid", exp.valid, id_ex.valid);
    check_value("reg_write", exp.reg_write, id_ex.reg_write);
    check_value("mem_write", exp.mem_write, id_ex.mem_write);
    check_value("mem_read", exp.mem_read, id_ex.mem_read);
    check_value("branch", exp.branch, id_ex.branch);
    check_value("jump", exp.jump, id_ex.jump);
    check_value("alu_op", exp.alu_op, id_ex.alu_op);
    check_value("alu_src_a", exp.alu_src_a, id_ex.alu_src_a);
    check_value("alu_src_b", exp.alu_src_b, id_ex.alu_src_b);
    check_value("result_src", exp.result_src, id_ex.result_src);
    check_value("funct3", exp.funct3, id_ex.funct3);
    check_value("rd", exp.rd, id_ex.rd);
    check_value("rs1", exp.rs1, id_ex.rs1);
    check_value("rs2", exp.rs2, id_ex.rs2);
    check_value("rd1", exp.rd1, id_ex.rd1);
    check_value("rd2", exp.rd2, id_ex.rd2);
    check_value("imm", exp.imm, id_ex.imm);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Vector loop
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int               fd;
    int               n;
    int               count;
    int               cycles;
    string            line;
    isa_pkg::data_t   col [0:20];
    ctrl_pkg::id_ex_t pending;

    instr       = '0;
    instr_valid = 1'b0;
    wb          = '0;
    count       = 0;
    cycles      = 0;
    // First check after reset expects the cleared bundle.
    pending     = '0;

    fd = $fopen("sim/decode_stim.txt", "r");
    if (fd == 0) begin
      $display("The stimulus file sim/decode_stim.txt is missing.");
      $display("STATUS: FAIL");
      $fatal(1, "Cannot open the stimulus file.");
    end

    // Still in reset here.
    @(negedge clk);
    compare_bundle('0);

    while (reset) begin
      @(posedge clk);
      cycles++;
      if (cycles > reset_timeout) begin
        $display("Reset was not released within %0d cycles.", reset_timeout);
        $display("STATUS: FAIL");
        $fatal(1, "Reset timeout.");
      end
    end

    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line,
                  "%h %d %d %d %h %d %d %d %d %d %d %d %d %d %d %d %d %d %h %h %h",
                  col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                  col[7], col[8], col[9], col[10], col[11], col[12], col[13],
                  col[14], col[15], col[16], col[17], col[18], col[19], col[20]);
      if (n <= 0) begin
        continue;
      end
      if (n != 21) begin
        $display("Malformed stimulus line after vector %0d.", count);
        $display("STATUS: FAIL");
        $fatal(1, "Bad stimulus line.");
      end
      count++;
      if (count > max_vectors) begin
        $display("The stimulus file is too long, over %0d vectors.", max_vectors);
        $display("STATUS: FAIL");
        $fatal(1, "Too many vectors.");
      end

      @(negedge clk);
      compare_bundle(pending);

      instr       = col[0];
      instr_valid = col[1][0];
      wb.en       = col[2][0];
      wb.rd       = col[3][4:0];
      wb.data     = col[4];

      pending            = '0;
      pending.valid      = col[5][0];
      pending.reg_write  = col[6][0];
      pending.mem_write  = col[7][0];
      pending.mem_read   = col[8][0];
      pending.branch     = col[9][0];
      pending.jump       = col[10][0];
      pending.alu_op     = ctrl_pkg::alu_op_t'(col[11][3:0]);
      pending.alu_src_a  = ctrl_pkg::alu_src_a_t'(col[12][1:0]);
      pending.alu_src_b  = ctrl_pkg::alu_src_b_t'(col[13][0]);
      pending.result_src = ctrl_pkg::result_src_t'(col[14][1:0]);
      // funct3 sits in bits 14:12 of every format.
      pending.funct3     = col[0][14:12];
      pending.rd         = col[15][4:0];
      pending.rs1        = col[16][4:0];
      pending.rs2        = col[17][4:0];
      pending.rd1        = col[18];
      pending.rd2        = col[19];
      pending.imm        = col[20];
    end
    $fclose(fd);

    @(negedge clk);
    compare_bundle(pending);

    if (count == 0) begin
      $display("The stimulus file holds no vectors.");
      $display("STATUS: FAIL");
      $fatal(1, "Empty stimulus file.");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// ==== sim/decode_stim.txt ====
// instr valid wb_en wb_rd wb_data | valid reg_write mem_write mem_read branch jump
// alu_op alu_src_a alu_src_b result_src rd rs1 rs2 (decimal) rd1 rd2 imm (hex)
006280b3 1 1  5 11111111 1 1 0 0 0 0  0 0 0 0  1  5  6 00000000 00000000 00000006
40628133 1 1  6 22222222 1 1 0 0 0 0  1 0 0 0  2  5  6 11111111 00000000 00000406
006291b3 1 1  0 deadbeef 1 1 0 0 0 0  2 0 0 0  3  5  6 11111111 22222222 00000006
00602233 1 0  0 00000000 1 1 0 0 0 0  3 0 0 0  4  0  6 00000000 22222222 00000006
005333b3 1 1 10 fffffff0 1 1 0 0 0 0  4 0 0 0  7  6  5 22222222 11111111 00000005
0062c433 1 0  0 00000000 1 1 0 0 0 0  5 0 0 0  8  5  6 11111111 22222222 00000006
0062d4b3 1 0  0 00000000 1 1 0 0 0 0  6 0 0 0  9  5  6 11111111 22222222 00000006
4062d5b3 1 0  0 00000000 1 1 0 0 0 0  7 0 0 0 11  5  6 11111111 22222222 00000406
00a2e633 1 0  0 00000000 1 1 0 0 0 0  8 0 0 0 12  5 10 11111111 fffffff0 0000000a
0062f6b3 1 0  0 00000000 1 1 0 0 0 0  9 0 0 0 13  5  6 11111111 22222222 00000006
fff28713 1 0  0 00000000 1 1 0 0 0 0  0 0 1 0 14  5 31 11111111 00000000 ffffffff
7ff30793 1 0  0 00000000 1 1 0 0 0 0  0 0 1 0 15  6 31 22222222 00000000 000007ff
00329813 1 0  0 00000000 1 1 0 0 0 0  2 0 1 0 16  5  3 11111111 00000000 00000003
0042d893 1 0  0 00000000 1 1 0 0 0 0  6 0 1 0 17  5  4 11111111 00000000 00000004
40455913 1 0  0 00000000 1 1 0 0 0 0  7 0 1 0 18 10  4 fffffff0 00000000 00000404
ffc32983 1 0  0 00000000 1 1 0 1 0 0  0 0 1 1 19  6 28 22222222 00000000 fffffffc
0102aa03 1 0  0 00000000 1 1 0 1 0 0  0 0 1 1 20  5 16 11111111 00000000 00000010
0062a423 1 0  0 00000000 1 0 1 0 0 0  0 0 1 0  8  5  6 11111111 22222222 00000008
fea32623 1 0  0 00000000 1 0 1 0 0 0  0 0 1 0 12  6 10 22222222 fffffff0 ffffffec
00628863 1 0  0 00000000 1 0 0 0 1 0  1 0 0 0 16  5  6 11111111 22222222 00000010
fe051ce3 1 0  0 00000000 1 0 0 0 1 0  1 0 0 0 25 10  0 fffffff0 00000000 fffffff8
12345ab7 1 0  0 00000000 1 1 0 0 0 0 10 2 1 0 21  8  3 00000000 00000000 12345000
fffffb37 1 0  0 00000000 1 1 0 0 0 0 10 2 1 0 22 31 31 00000000 00000000 fffff000
80000b97 1 0  0 00000000 1 1 0 0 0 0  0 1 1 0 23  0  0 00000000 00000000 80000000
00001c17 1 0  0 00000000 1 1 0 0 0 0  0 1 1 0 24  0  0 00000000 00000000 00001000
001000ef 1 0  0 00000000 1 1 0 0 0 1  0 1 1 2  1  0  1 00000000 00000000 00000800
ffdff06f 1 0  0 00000000 1 1 0 0 0 1  0 1 1 2  0 31 29 00000000 00000000 fffffffc
00c28ce7 1 0  0 00000000 1 1 0 0 0 1  0 0 1 2 25  5 12 11111111 00000000 0000000c
80030d67 1 0  0 00000000 1 1 0 0 0 1  0 0 1 2 26  6  0 22222222 00000000 fffff800
006280b3 0 0  0 00000000 0 0 0 0 0 0  0 0 0 0  1  5  6 11111111 22222222 00000006
0ff0000f 1 0  0 00000000 0 0 0 0 0 0  0 0 0 0  0  0 31 00000000 00000000 000000ff
00000073 1 0  0 00000000 0 0 0 0 0 0  0 0 0 0  0  0  0 00000000 00000000 00000000

// ==== verilog.f ====
verilog/isa_pkg.sv
verilog/ctrl_pkg.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/decode_stage.sv
sim/clk_gen.sv
sim/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - files:
      - verilog/isa_pkg.sv
      - verilog/ctrl_pkg.sv
      - verilog/instr_decoder.sv
      - verilog/reg_file.sv
      - verilog/decode_stage.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/tb_decode_stage.sv
